//--- isa_pkg.sv
package isa_pkg;

  // --------------------------------------------------
  // instruction fields
  // --------------------------------------------------
  typedef logic [6:0] opcode_t;
  typedef logic [4:0] reg_addr_t;

  localparam opcode_t OPC_OP     = 7'b0110011; // register-register ops
  localparam opcode_t OPC_OP_IMM = 7'b0010011; // register-immediate ops

  // funct3 values of the kept ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // turns add into sub

  // --------------------------------------------------
  // alu operations
  // --------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_t;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

  // --------------------------------------------------
  // operand sources for the bypass network
  // --------------------------------------------------
  // ex sources carry the alu output of the pair one ahead,
  // wb sources the registered result of the pair two ahead
  typedef enum logic [2:0] {
    FWD_RF,   // register file, also used for x0
    FWD_EX_A,
    FWD_EX_B,
    FWD_WB_A,
    FWD_WB_B
  } fwd_src_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder #(
  parameter int XLEN = 64
) (
  input  logic [31:0]        instr,
  output isa_pkg::alu_op_t   alu_op,
  output isa_pkg::reg_addr_t rd,
  output isa_pkg::reg_addr_t rs1,
  output isa_pkg::reg_addr_t rs2,
  output logic               use_imm,
  output logic [XLEN-1:0]    imm,
  output logic               wr_en
);

  isa_pkg::opcode_t opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign imm = {{(XLEN-12){instr[31]}}, instr[31:20]}; // i-type, sign extended

  always_comb begin
    alu_op  = isa_pkg::ALU_ADD;
    use_imm = 1'b0;
    wr_en   = 1'b0; // anything not matched below writes nothing
    if (opcode == isa_pkg::OPC_OP) begin
      wr_en = (funct7 == 7'b0);
      case (funct3)
        isa_pkg::F3_ADD_SUB: begin
          alu_op = (funct7 == isa_pkg::F7_ALT) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
          wr_en  = (funct7 == 7'b0) || (funct7 == isa_pkg::F7_ALT);
        end
        isa_pkg::F3_SLL: alu_op = isa_pkg::ALU_SLL;
        isa_pkg::F3_SLT: alu_op = isa_pkg::ALU_SLT;
        isa_pkg::F3_XOR: alu_op = isa_pkg::ALU_XOR;
        isa_pkg::F3_SRL: alu_op = isa_pkg::ALU_SRL; // sra has F7_ALT, not kept
        isa_pkg::F3_OR:  alu_op = isa_pkg::ALU_OR;
        isa_pkg::F3_AND: alu_op = isa_pkg::ALU_AND;
        default:         wr_en  = 1'b0; // sltu
      endcase
    end else if (opcode == isa_pkg::OPC_OP_IMM) begin
      use_imm = 1'b1;
      wr_en   = 1'b1;
      case (funct3)
        isa_pkg::F3_ADD_SUB: alu_op = isa_pkg::ALU_ADD;
        isa_pkg::F3_SLT:     alu_op = isa_pkg::ALU_SLT;
        isa_pkg::F3_XOR:     alu_op = isa_pkg::ALU_XOR;
        isa_pkg::F3_OR:      alu_op = isa_pkg::ALU_OR;
        isa_pkg::F3_AND:     alu_op = isa_pkg::ALU_AND;
        default:             wr_en  = 1'b0; // immediate shifts and sltiu
      endcase
    end
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               issue_valid,
  input  logic [31:0]        instr_a,
  input  logic [31:0]        instr_b,
  output isa_pkg::alu_op_t   alu_op_a,
  output isa_pkg::reg_addr_t rd_a,
  output isa_pkg::reg_addr_t rs1_a,
  output isa_pkg::reg_addr_t rs2_a,
  output logic               use_imm_a,
  output logic [XLEN-1:0]    imm_a,
  output logic               wr_en_a,
  output isa_pkg::alu_op_t   alu_op_b,
  output isa_pkg::reg_addr_t rd_b,
  output isa_pkg::reg_addr_t rs1_b,
  output isa_pkg::reg_addr_t rs2_b,
  output logic               use_imm_b,
  output logic [XLEN-1:0]    imm_b,
  output logic               wr_en_b
);

  logic        pair_valid;
  logic [31:0] pair_a;     // older instruction
  logic [31:0] pair_b;
  logic        dec_wr_a;
  logic        dec_wr_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= issue_valid; // low issue turns into a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      pair_a <= instr_a;
      pair_b <= instr_b;
    end
  end

  instr_decoder #(.XLEN(XLEN)) u_dec_a (
    .instr(pair_a), .alu_op(alu_op_a), .rd(rd_a), .rs1(rs1_a), .rs2(rs2_a),
    .use_imm(use_imm_a), .imm(imm_a), .wr_en(dec_wr_a)
  );

  instr_decoder #(.XLEN(XLEN)) u_dec_b (
    .instr(pair_b), .alu_op(alu_op_b), .rd(rd_b), .rs1(rs1_b), .rs2(rs2_b),
    .use_imm(use_imm_b), .imm(imm_b), .wr_en(dec_wr_b)
  );

  assign wr_en_a = pair_valid & dec_wr_a;
  assign wr_en_b = pair_valid & dec_wr_b;

  // lane b has no path to lane a's result in the same pair
  a_no_intra_pair_dep : assert property (@(posedge clk) disable iff (reset)
    (wr_en_a && wr_en_b && (rd_a != '0)) |->
      ((rs1_b != rd_a) && (use_imm_b || (rs2_b != rd_a))));

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  isa_pkg::reg_addr_t raddr0,
  input  isa_pkg::reg_addr_t raddr1,
  input  isa_pkg::reg_addr_t raddr2,
  input  isa_pkg::reg_addr_t raddr3,
  output logic [XLEN-1:0]    rdata0,
  output logic [XLEN-1:0]    rdata1,
  output logic [XLEN-1:0]    rdata2,
  output logic [XLEN-1:0]    rdata3,
  input  logic               we_a,
  input  isa_pkg::reg_addr_t waddr_a,
  input  logic [XLEN-1:0]    wdata_a,
  input  logic               we_b,
  input  isa_pkg::reg_addr_t waddr_b,
  input  logic [XLEN-1:0]    wdata_b
);

  logic [XLEN-1:0] regs [32];

  // port b comes last so it wins on a same-address write
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      if (we_a && (waddr_a != '0)) regs[waddr_a] <= wdata_a;
      if (we_b && (waddr_b != '0)) regs[waddr_b] <= wdata_b;
    end
  end

  // reads are combinational, no write-through
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
  assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

  a_x0_untouched : assert property (@(posedge clk) disable iff (reset)
    ((we_a && (waddr_a == '0)) || (we_b && (waddr_b == '0))) |=> (regs[0] == '0));

endmodule

//--- forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
  input  isa_pkg::reg_addr_t  rs1_a,
  input  isa_pkg::reg_addr_t  rs2_a,
  input  isa_pkg::reg_addr_t  rs1_b,
  input  isa_pkg::reg_addr_t  rs2_b,
  input  isa_pkg::reg_addr_t  ex_rd_a,
  input  logic                ex_wr_a,
  input  isa_pkg::reg_addr_t  ex_rd_b,
  input  logic                ex_wr_b,
  input  isa_pkg::reg_addr_t  wb_rd_a,
  input  logic                wb_wr_a,
  input  isa_pkg::reg_addr_t  wb_rd_b,
  input  logic                wb_wr_b,
  output pipe_pkg::fwd_src_t  sel_rs1_a,
  output pipe_pkg::fwd_src_t  sel_rs2_a,
  output pipe_pkg::fwd_src_t  sel_rs1_b,
  output pipe_pkg::fwd_src_t  sel_rs2_b
);

  // newest producer first, lane b younger than lane a
  function automatic pipe_pkg::fwd_src_t pick(
    input isa_pkg::reg_addr_t rs,
    input isa_pkg::reg_addr_t exa, input logic exa_wr,
    input isa_pkg::reg_addr_t exb, input logic exb_wr,
    input isa_pkg::reg_addr_t wba, input logic wba_wr,
    input isa_pkg::reg_addr_t wbb, input logic wbb_wr
  );
    if (rs == '0)                    return pipe_pkg::FWD_RF; // x0 is never bypassed
    else if (exb_wr && (exb == rs)) return pipe_pkg::FWD_EX_B;
    else if (exa_wr && (exa == rs)) return pipe_pkg::FWD_EX_A;
    else if (wbb_wr && (wbb == rs)) return pipe_pkg::FWD_WB_B;
    else if (wba_wr && (wba == rs)) return pipe_pkg::FWD_WB_A;
    else                             return pipe_pkg::FWD_RF;
  endfunction

  always_comb begin
    sel_rs1_a = pick(rs1_a, ex_rd_a, ex_wr_a, ex_rd_b, ex_wr_b,
                     wb_rd_a, wb_wr_a, wb_rd_b, wb_wr_b);
    sel_rs2_a = pick(rs2_a, ex_rd_a, ex_wr_a, ex_rd_b, ex_wr_b,
                     wb_rd_a, wb_wr_a, wb_rd_b, wb_wr_b);
    sel_rs1_b = pick(rs1_b, ex_rd_a, ex_wr_a, ex_rd_b, ex_wr_b,
                     wb_rd_a, wb_wr_a, wb_rd_b, wb_wr_b);
    sel_rs2_b = pick(rs2_b, ex_rd_a, ex_wr_a, ex_rd_b, ex_wr_b,
                     wb_rd_a, wb_wr_a, wb_rd_b, wb_wr_b);
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu #(
  parameter int XLEN = 64
) (
  input  isa_pkg::alu_op_t op,
  input  logic [XLEN-1:0]  a,
  input  logic [XLEN-1:0]  b,
  output logic [XLEN-1:0]  y
);

  logic [5:0] shamt; // shift amount from the low bits of b
  logic       lt;

  assign shamt = b[5:0];
  assign lt    = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      isa_pkg::ALU_ADD: y = a + b;
      isa_pkg::ALU_SUB: y = a - b;
      isa_pkg::ALU_AND: y = a & b;
      isa_pkg::ALU_OR:  y = a | b;
      isa_pkg::ALU_XOR: y = a ^ b;
      isa_pkg::ALU_SLL: y = a << shamt;
      isa_pkg::ALU_SRL: y = a >> shamt; // logical
      isa_pkg::ALU_SLT: y = {{(XLEN-1){1'b0}}, lt};
      default:          y = '0;
    endcase
  end

endmodule

//--- execute_lane.sv
`timescale 1ns/1ps

module execute_lane #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  isa_pkg::alu_op_t   alu_op,
  input  isa_pkg::reg_addr_t rd,
  input  logic               use_imm,
  input  logic [XLEN-1:0]    imm,
  input  logic               wr_en,
  input  pipe_pkg::fwd_src_t sel_rs1,
  input  pipe_pkg::fwd_src_t sel_rs2,
  input  logic [XLEN-1:0]    rf_rs1,
  input  logic [XLEN-1:0]    rf_rs2,
  input  logic [XLEN-1:0]    ex_result_a,
  input  logic [XLEN-1:0]    ex_result_b,
  input  logic [XLEN-1:0]    wb_data_a,
  input  logic [XLEN-1:0]    wb_data_b,
  output isa_pkg::reg_addr_t ex_rd,
  output logic               ex_wr_en,
  output logic [XLEN-1:0]    ex_result,
  output logic               wb_valid,
  output isa_pkg::reg_addr_t wb_rd,
  output logic [XLEN-1:0]    wb_data
);

  isa_pkg::alu_op_t op_q;
  logic [XLEN-1:0]  opa;
  logic [XLEN-1:0]  opb;
  logic [XLEN-1:0]  opa_q;
  logic [XLEN-1:0]  opb_q;

  function automatic logic [XLEN-1:0] bypass(
    input pipe_pkg::fwd_src_t sel, input logic [XLEN-1:0] rf,
    input logic [XLEN-1:0] exa, input logic [XLEN-1:0] exb,
    input logic [XLEN-1:0] wba, input logic [XLEN-1:0] wbb
  );
    case (sel)
      pipe_pkg::FWD_EX_A: return exa;
      pipe_pkg::FWD_EX_B: return exb;
      pipe_pkg::FWD_WB_A: return wba;
      pipe_pkg::FWD_WB_B: return wbb;
      default:            return rf;
    endcase
  endfunction

  always_comb begin
    opa = bypass(sel_rs1, rf_rs1, ex_result_a, ex_result_b, wb_data_a, wb_data_b);
    opb = use_imm ? imm
                  : bypass(sel_rs2, rf_rs2, ex_result_a, ex_result_b, wb_data_a, wb_data_b);
  end

  // --------------------------------------------------
  // decode to execute
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_wr_en <= 1'b0;
    end else begin
      ex_wr_en <= wr_en; // already low for a bubble
    end
  end

  always_ff @(posedge clk) begin
    op_q  <= alu_op;
    opa_q <= opa;
    opb_q <= opb;
    ex_rd <= rd;
  end

  alu #(.XLEN(XLEN)) u_alu (.op(op_q), .a(opa_q), .b(opb_q), .y(ex_result));

  // --------------------------------------------------
  // execute to write-back
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_wr_en && (ex_rd != '0); // x0 results are dropped here
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= ex_rd;
    wb_data <= ex_result;
  end

  // a valid write-back always names a real register
  a_no_x0_writeback : assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_rd != '0));

endmodule

//--- dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               issue_valid,
  input  logic [31:0]        instr_a,
  input  logic [31:0]        instr_b,
  output logic               wb_valid_a,
  output isa_pkg::reg_addr_t wb_rd_a,
  output logic [XLEN-1:0]    wb_data_a,
  output logic               wb_valid_b,
  output isa_pkg::reg_addr_t wb_rd_b,
  output logic [XLEN-1:0]    wb_data_b
);

  // decoded fields per lane
  isa_pkg::alu_op_t   alu_op_a, alu_op_b;
  isa_pkg::reg_addr_t rd_a, rs1_a, rs2_a;
  isa_pkg::reg_addr_t rd_b, rs1_b, rs2_b;
  logic               use_imm_a, use_imm_b;
  logic [XLEN-1:0]    imm_a, imm_b;
  logic               wr_en_a, wr_en_b;

  logic [XLEN-1:0]    rf_rs1_a, rf_rs2_a, rf_rs1_b, rf_rs2_b;
  pipe_pkg::fwd_src_t sel_rs1_a, sel_rs2_a, sel_rs1_b, sel_rs2_b;

  // execute stage state, fed back for bypass
  isa_pkg::reg_addr_t ex_rd_a, ex_rd_b;
  logic               ex_wr_en_a, ex_wr_en_b;
  logic [XLEN-1:0]    ex_result_a, ex_result_b;

  decode_stage #(.XLEN(XLEN)) u_decode_stage (
    .clk(clk), .reset(reset), .issue_valid(issue_valid),
    .instr_a(instr_a), .instr_b(instr_b),
    .alu_op_a(alu_op_a), .rd_a(rd_a), .rs1_a(rs1_a), .rs2_a(rs2_a),
    .use_imm_a(use_imm_a), .imm_a(imm_a), .wr_en_a(wr_en_a),
    .alu_op_b(alu_op_b), .rd_b(rd_b), .rs1_b(rs1_b), .rs2_b(rs2_b),
    .use_imm_b(use_imm_b), .imm_b(imm_b), .wr_en_b(wr_en_b)
  );

  // write ports take the write-back registers, landing one edge later
  reg_file #(.XLEN(XLEN)) u_reg_file (
    .clk(clk), .reset(reset),
    .raddr0(rs1_a), .raddr1(rs2_a), .raddr2(rs1_b), .raddr3(rs2_b),
    .rdata0(rf_rs1_a), .rdata1(rf_rs2_a), .rdata2(rf_rs1_b), .rdata3(rf_rs2_b),
    .we_a(wb_valid_a), .waddr_a(wb_rd_a), .wdata_a(wb_data_a),
    .we_b(wb_valid_b), .waddr_b(wb_rd_b), .wdata_b(wb_data_b)
  );

  forward_unit u_forward_unit (
    .rs1_a(rs1_a), .rs2_a(rs2_a), .rs1_b(rs1_b), .rs2_b(rs2_b),
    .ex_rd_a(ex_rd_a), .ex_wr_a(ex_wr_en_a), .ex_rd_b(ex_rd_b), .ex_wr_b(ex_wr_en_b),
    .wb_rd_a(wb_rd_a), .wb_wr_a(wb_valid_a), .wb_rd_b(wb_rd_b), .wb_wr_b(wb_valid_b),
    .sel_rs1_a(sel_rs1_a), .sel_rs2_a(sel_rs2_a),
    .sel_rs1_b(sel_rs1_b), .sel_rs2_b(sel_rs2_b)
  );

  execute_lane #(.XLEN(XLEN)) u_lane_a (
    .clk(clk), .reset(reset),
    .alu_op(alu_op_a), .rd(rd_a), .use_imm(use_imm_a), .imm(imm_a), .wr_en(wr_en_a),
    .sel_rs1(sel_rs1_a), .sel_rs2(sel_rs2_a), .rf_rs1(rf_rs1_a), .rf_rs2(rf_rs2_a),
    .ex_result_a(ex_result_a), .ex_result_b(ex_result_b),
    .wb_data_a(wb_data_a), .wb_data_b(wb_data_b),
    .ex_rd(ex_rd_a), .ex_wr_en(ex_wr_en_a), .ex_result(ex_result_a),
    .wb_valid(wb_valid_a), .wb_rd(wb_rd_a), .wb_data(wb_data_a)
  );

  execute_lane #(.XLEN(XLEN)) u_lane_b (
    .clk(clk), .reset(reset),
    .alu_op(alu_op_b), .rd(rd_b), .use_imm(use_imm_b), .imm(imm_b), .wr_en(wr_en_b),
    .sel_rs1(sel_rs1_b), .sel_rs2(sel_rs2_b), .rf_rs1(rf_rs1_b), .rf_rs2(rf_rs2_b),
    .ex_result_a(ex_result_a), .ex_result_b(ex_result_b),
    .wb_data_a(wb_data_a), .wb_data_b(wb_data_b),
    .ex_rd(ex_rd_b), .ex_wr_en(ex_wr_en_b), .ex_result(ex_result_b),
    .wb_valid(wb_valid_b), .wb_rd(wb_rd_b), .wb_data(wb_data_b)
  );

endmodule

//--- tb_dual_issue_core.sv
`timescale 1ns/1ps

module tb_dual_issue_core;

  localparam int XLEN = 64;

  // instructions the stimulus can issue, K_BAD is a load and not supported
  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_SLT,
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_BAD
  } kind_t;

  typedef struct packed {
    kind_t      kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
  } op_desc_t;

  typedef struct packed {
    logic [31:0]     tag;  // rising edge on which the pair was sampled
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } wb_exp_t;

  logic               clk;
  logic               reset;
  logic               issue_valid;
  logic [31:0]        instr_a;
  logic [31:0]        instr_b;
  logic               wb_valid_a;
  isa_pkg::reg_addr_t wb_rd_a;
  logic [XLEN-1:0]    wb_data_a;
  logic               wb_valid_b;
  isa_pkg::reg_addr_t wb_rd_b;
  logic [XLEN-1:0]    wb_data_b;

  logic [31:0]     edge_cnt = '0;
  logic [XLEN-1:0] model [32];  // architectural state in program order
  wb_exp_t         exp_a [$];
  wb_exp_t         exp_b [$];

  dual_issue_core #(.XLEN(XLEN)) u_dual_issue_core (
    .clk(clk), .reset(reset), .issue_valid(issue_valid),
    .instr_a(instr_a), .instr_b(instr_b),
    .wb_valid_a(wb_valid_a), .wb_rd_a(wb_rd_a), .wb_data_a(wb_data_a),
    .wb_valid_b(wb_valid_b), .wb_rd_b(wb_rd_b), .wb_data_b(wb_data_b)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) edge_cnt <= edge_cnt + 32'd1;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [XLEN-1:0] alu_ref(input isa_pkg::alu_op_t op,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (op)
      isa_pkg::ALU_ADD: return a + b;
      isa_pkg::ALU_SUB: return a - b;
      isa_pkg::ALU_AND: return a & b;
      isa_pkg::ALU_OR:  return a | b;
      isa_pkg::ALU_XOR: return a ^ b;
      isa_pkg::ALU_SLL: return a << b[5:0];
      isa_pkg::ALU_SRL: return a >> b[5:0];
      isa_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      default:          return '0;
    endcase
  endfunction

  function automatic logic is_imm(input kind_t k);
    return (k >= K_ADDI) && (k <= K_SLTI);
  endfunction

  function automatic isa_pkg::alu_op_t kind_to_op(input kind_t k);
    case (k)
      K_SUB:          return isa_pkg::ALU_SUB;
      K_AND, K_ANDI:  return isa_pkg::ALU_AND;
      K_OR, K_ORI:    return isa_pkg::ALU_OR;
      K_XOR, K_XORI:  return isa_pkg::ALU_XOR;
      K_SLL:          return isa_pkg::ALU_SLL;
      K_SRL:          return isa_pkg::ALU_SRL;
      K_SLT, K_SLTI:  return isa_pkg::ALU_SLT;
      default:        return isa_pkg::ALU_ADD;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] lane_result(input op_desc_t d);
    logic [XLEN-1:0] b;
    b = is_imm(d.kind) ? {{(XLEN-12){d.imm[11]}}, d.imm} : model[d.rs2];
    return alu_ref(kind_to_op(d.kind), model[d.rs1], b);
  endfunction

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic logic [31:0] encode(input op_desc_t d);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (d.kind == K_SUB) ? isa_pkg::F7_ALT : 7'b0;
    case (d.kind)
      K_AND, K_ANDI:        f3 = isa_pkg::F3_AND;
      K_OR, K_ORI:          f3 = isa_pkg::F3_OR;
      K_XOR, K_XORI:        f3 = isa_pkg::F3_XOR;
      K_SLL:                f3 = isa_pkg::F3_SLL;
      K_SRL:                f3 = isa_pkg::F3_SRL;
      K_SLT, K_SLTI, K_BAD: f3 = isa_pkg::F3_SLT; // lw shares funct3 with slt
      default:              f3 = isa_pkg::F3_ADD_SUB;
    endcase
    if (d.kind == K_BAD) return {d.imm, d.rs1, f3, d.rd, 7'b0000011};
    else if (is_imm(d.kind)) return {d.imm, d.rs1, f3, d.rd, isa_pkg::OPC_OP_IMM};
    else return {f7, d.rs2, d.rs1, f3, d.rd, isa_pkg::OPC_OP};
  endfunction

  function automatic op_desc_t mk(input kind_t k, input int rd, input int rs1,
                                  input int rs2, input int imm);
    op_desc_t d;
    d.kind = k;
    d.rd   = 5'(rd);
    d.rs1  = 5'(rs1);
    d.rs2  = 5'(rs2);
    d.imm  = 12'(imm);
    return d;
  endfunction

  function automatic op_desc_t rand_desc();
    op_desc_t d;
    d.kind = kind_t'($urandom_range(0, 12));
    d.rd   = 5'($urandom_range(0, 15)); // small range for frequent hazards
    d.rs1  = 5'($urandom_range(0, 15));
    d.rs2  = 5'($urandom_range(0, 15));
    d.imm  = 12'($urandom);
    return d;
  endfunction

  function automatic wb_exp_t make_exp(input logic [4:0] rd, input logic [XLEN-1:0] data);
    wb_exp_t e;
    e.tag  = edge_cnt + 32'd1;
    e.rd   = rd;
    e.data = data;
    return e;
  endfunction

  task automatic issue_pair(input op_desc_t a, input op_desc_t b);
    logic [XLEN-1:0] res;
    @(negedge clk);
    issue_valid = 1'b1;
    instr_a     = encode(a);
    instr_b     = encode(b);
    res = lane_result(a); // lane a is older
    if (a.kind != K_BAD && a.rd != 5'd0) begin
      model[a.rd] = res;
      exp_a.push_back(make_exp(a.rd, res));
    end
    res = lane_result(b);
    if (b.kind != K_BAD && b.rd != 5'd0) begin
      model[b.rd] = res;
      exp_b.push_back(make_exp(b.rd, res));
    end
  endtask

  task automatic issue_bubble();
    @(negedge clk);
    issue_valid = 1'b0;
    instr_a     = $urandom; // must be ignored
    instr_b     = $urandom;
  endtask

  task automatic fail_now();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // --------------------------------------------------
  // comparison
  // --------------------------------------------------
  task automatic check_wb(input string lane, input logic valid, input logic [4:0] rd,
                          input logic [XLEN-1:0] data, input logic have, input wb_exp_t e);
    assert (valid === have) else begin
      $display("[FAIL] time %0t: wb_valid_%s expected %b actual %b", $time, lane, have, valid);
      fail_now();
    end
    if (have) begin
      assert (rd === e.rd) else begin
        $display("[FAIL] time %0t: wb_rd_%s expected %0d actual %0d", $time, lane, e.rd, rd);
        fail_now();
      end
      assert (data === e.data) else begin
        $display("[FAIL] time %0t: wb_data_%s expected %h actual %h",
                 $time, lane, e.data, data);
        fail_now();
      end
    end
  endtask

  // outputs settle after the rising edge, so they are checked half a cycle later
  always @(negedge clk) begin : compare_wb
    logic    have;
    wb_exp_t e;
    if (edge_cnt > 32'd0) begin
      have = (exp_a.size() > 0) && (exp_a[0].tag + 32'd2 == edge_cnt);
      e    = '0;
      if (have) e = exp_a[0];
      check_wb("a", wb_valid_a, wb_rd_a, wb_data_a, have, e);
      if (have) void'(exp_a.pop_front());
      have = (exp_b.size() > 0) && (exp_b[0].tag + 32'd2 == edge_cnt);
      e    = '0;
      if (have) e = exp_b[0];
      check_wb("b", wb_valid_b, wb_rd_b, wb_data_b, have, e);
      if (have) void'(exp_b.pop_front());
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : stimulus
    int unsigned seed_ret;
    int          timeout;
    op_desc_t    a;
    op_desc_t    b;
    seed_ret    = $urandom(32'he7a6_0b36);
    reset       = 1'b1;
    issue_valid = 1'b0;
    instr_a     = '0;
    instr_b     = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) issue_bubble(); // no write-back may show up here

    // chains across lanes, from ex, wb and the register file
    issue_pair(mk(K_ADDI, 1, 0, 0, 100), mk(K_ADDI, 2, 0, 0, -7));
    issue_pair(mk(K_ADD, 3, 2, 1, 0), mk(K_SUB, 4, 1, 2, 0));
    issue_pair(mk(K_XOR, 5, 4, 1, 0), mk(K_OR, 6, 3, 2, 0));
    issue_pair(mk(K_SLT, 7, 2, 1, 0), mk(K_AND, 8, 6, 5, 0));
    issue_pair(mk(K_SLL, 9, 5, 4, 0), mk(K_SRL, 10, 8, 7, 0));
    issue_pair(mk(K_ADDI, 11, 10, 0, 5), mk(K_XORI, 12, 9, 0, -1));
    issue_bubble();
    issue_pair(mk(K_ADD, 13, 12, 11, 0), mk(K_ORI, 14, 11, 0, 'h0f0));
    repeat (2) issue_bubble();
    issue_pair(mk(K_SUB, 15, 13, 14, 0), mk(K_ANDI, 1, 13, 0, 'h7ff));

    // same rd in both lanes, lane b must win in ex, wb and the register file
    issue_pair(mk(K_ADDI, 7, 0, 0, 11), mk(K_ADDI, 7, 0, 0, 22));
    issue_pair(mk(K_ADD, 8, 7, 0, 0), mk(K_ADDI, 9, 7, 0, 1));
    issue_pair(mk(K_ADDI, 7, 0, 0, 33), mk(K_ADDI, 7, 0, 0, 44));
    issue_bubble();
    issue_pair(mk(K_OR, 10, 7, 0, 0), mk(K_XOR, 11, 7, 7, 0));
    issue_pair(mk(K_ADDI, 6, 0, 0, -5), mk(K_ADDI, 6, 0, 0, -6));
    repeat (2) issue_bubble();
    issue_pair(mk(K_ADD, 12, 6, 6, 0), mk(K_SLTI, 13, 6, 0, 0));

    // x0 destinations, x0 reads and an unsupported opcode
    issue_pair(mk(K_ADDI, 0, 1, 0, 123), mk(K_ADD, 0, 2, 3, 0));
    issue_pair(mk(K_ADD, 2, 0, 0, 0), mk(K_ORI, 3, 0, 0, 0));
    issue_pair(mk(K_BAD, 4, 1, 0, 0), mk(K_ADDI, 5, 1, 0, 1));

    // every op in both lanes with random operands
    for (int r = 1; r < 15; r += 2) begin
      issue_pair(mk(K_ADDI, r, 0, 0, $urandom), mk(K_ADDI, r + 1, 0, 0, $urandom));
    end
    for (int k = 0; k < 13; k++) begin
      a      = rand_desc();
      b      = rand_desc();
      a.kind = kind_t'(k);
      b.kind = kind_t'(k);
      if (a.rd != 5'd0 && b.rs1 == a.rd) b.rs1 = a.rd ^ 5'd1;
      if (a.rd != 5'd0 && b.rs2 == a.rd) b.rs2 = a.rd ^ 5'd1;
      issue_pair(a, b);
    end
    for (int n = 0; n < 400; n++) begin
      if ($urandom_range(0, 7) == 0) begin
        issue_bubble();
      end else begin
        a = rand_desc();
        b = rand_desc();
        if (a.rd != 5'd0 && b.rs1 == a.rd) b.rs1 = a.rd ^ 5'd1; // keep the pair legal
        if (a.rd != 5'd0 && b.rs2 == a.rd) b.rs2 = a.rd ^ 5'd1;
        issue_pair(a, b);
      end
    end

    issue_bubble();
    timeout = 0;
    while ((exp_a.size() != 0 || exp_b.size() != 0) && timeout < 20) begin
      @(posedge clk);
      timeout++;
    end
    repeat (2) @(posedge clk);
    if (exp_a.size() != 0 || exp_b.size() != 0) begin
      $display("ERROR: %0d lane a and %0d lane b write-backs never appeared",
               exp_a.size(), exp_b.size());
      fail_now();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- flist.f
isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
decode_stage.sv
reg_file.sv
forward_unit.sv
alu.sv
execute_lane.sv
dual_issue_core.sv
tb_dual_issue_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dual_issue_core -f flist.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
